/* exe_pkg.sv */
// **********************************************************
// shared word types, instruction class and operation enums,
// and the machine CSR addresses of the execute stage.
// **********************************************************

`default_nettype none

package exe_pkg;

  typedef logic [63:0] word_t;     // operands, pc, results.
  typedef logic [31:0] inst_t;     // raw instruction word.
  typedef logic [4:0]  ridx_t;     // register index.
  typedef logic [11:0] csr_addr_t; // csr address.

  typedef enum logic [4:0] {
    TYPE_NONE   = 5'd0,
    TYPE_ALU    = 5'd1,
    TYPE_BRANCH = 5'd2,
    TYPE_JUMP   = 5'd3,
    TYPE_CSR    = 5'd4
  } inst_type_e;

  typedef enum logic [7:0] {
    OP_ADD   = 8'd0,
    OP_SUB   = 8'd1,
    OP_AND   = 8'd2,
    OP_OR    = 8'd3,
    OP_XOR   = 8'd4,
    OP_SLL   = 8'd5,
    OP_SRL   = 8'd6,
    OP_SRA   = 8'd7,
    OP_SLT   = 8'd8,
    OP_SLTU  = 8'd9,
    OP_BEQ   = 8'd16,
    OP_BNE   = 8'd17,
    OP_BLT   = 8'd18,
    OP_BGE   = 8'd19,
    OP_BLTU  = 8'd20,
    OP_BGEU  = 8'd21,
    OP_JAL   = 8'd32,
    OP_CSRRW = 8'd48,
    OP_CSRRS = 8'd49,
    OP_CSRRC = 8'd50
  } op_e;

  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;

endpackage

`default_nettype wire

/* csr_if.sv */
// **********************************************************
// csr access path between the execute unit and the csr block.
// **********************************************************

`timescale 1ns/10ps
`default_nettype none

interface csr_if;

  exe_pkg::csr_addr_t addr;
  logic               ren;
  logic               wen;
  exe_pkg::word_t     wdata;
  exe_pkg::word_t     rdata;  // combinational from addr.
  logic               hit;    // address is implemented.

  modport unit (output addr, output ren, output wen, output wdata,
                input rdata, input hit);

  modport regs (input addr, input ren, input wen, input wdata,
                output rdata, output hit);

endinterface

`default_nettype wire

/* csr_regs.sv */
// **********************************************************
// machine csr registers mtvec, mscratch, mepc and mcause.
// **********************************************************

`timescale 1ns/10ps
`default_nettype none

module csr_regs (
  input logic clk,
  input logic rst,
  csr_if.regs csr
);

  exe_pkg::word_t mtvec;
  exe_pkg::word_t mscratch;
  exe_pkg::word_t mepc;
  exe_pkg::word_t mcause;

  // address decode and read.
  always_comb begin
    csr.hit   = 1'b1;
    csr.rdata = '0;
    case (csr.addr)
      exe_pkg::CSR_MTVEC:    csr.rdata = mtvec;
      exe_pkg::CSR_MSCRATCH: csr.rdata = mscratch;
      exe_pkg::CSR_MEPC:     csr.rdata = mepc;
      exe_pkg::CSR_MCAUSE:   csr.rdata = mcause;
      default:               csr.hit   = 1'b0;
    endcase
    if (!csr.ren) begin
      csr.rdata = '0;  // quiet bus when nobody reads.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
    end else if (csr.wen && csr.hit) begin
      case (csr.addr)
        exe_pkg::CSR_MTVEC:    mtvec    <= {csr.wdata[63:2], 2'b00}; // aligned base.
        exe_pkg::CSR_MSCRATCH: mscratch <= csr.wdata;
        exe_pkg::CSR_MEPC:     mepc     <= csr.wdata;
        exe_pkg::CSR_MCAUSE:   mcause   <= csr.wdata;
        default:               mcause   <= mcause;
      endcase
    end
  end

endmodule

`default_nettype wire

/* exe_unit.sv */
// **********************************************************
// combinational execute unit for alu, branch, jal and csr ops.
// **********************************************************

`timescale 1ns/10ps
`default_nettype none

module exe_unit (
  input  logic                i_ena,
  input  exe_pkg::inst_type_e i_inst_type,
  input  exe_pkg::op_e        i_op,
  input  exe_pkg::word_t      i_pc,
  input  exe_pkg::word_t      i_op1,
  input  exe_pkg::word_t      i_op2,
  input  exe_pkg::word_t      i_op3,
  input  logic                i_commit,
  csr_if.unit                 csr,
  output logic                o_pc_jmp,
  output exe_pkg::word_t      o_pc_jmpaddr,
  output exe_pkg::word_t      o_rd_wdata,
  output logic                o_force_nowen,
  output logic                o_skip_cmt
);

  logic [5:0]     shamt;
  exe_pkg::word_t alu_res;
  exe_pkg::word_t jal_sum;
  exe_pkg::word_t csr_new;
  logic           br_taken;
  logic           is_csr;

  assign shamt   = i_op2[5:0];
  assign jal_sum = i_op1 + i_op2;

  always_comb begin
    case (i_op)
      exe_pkg::OP_ADD:  alu_res = i_op1 + i_op2;
      exe_pkg::OP_SUB:  alu_res = i_op1 - i_op2;
      exe_pkg::OP_AND:  alu_res = i_op1 & i_op2;
      exe_pkg::OP_OR:   alu_res = i_op1 | i_op2;
      exe_pkg::OP_XOR:  alu_res = i_op1 ^ i_op2;
      exe_pkg::OP_SLL:  alu_res = i_op1 << shamt;
      exe_pkg::OP_SRL:  alu_res = i_op1 >> shamt;
      exe_pkg::OP_SRA:  alu_res = $signed(i_op1) >>> shamt;
      exe_pkg::OP_SLT:  alu_res = {63'd0, $signed(i_op1) < $signed(i_op2)};
      exe_pkg::OP_SLTU: alu_res = {63'd0, i_op1 < i_op2};
      default:          alu_res = '0;
    endcase
  end

  always_comb begin
    case (i_op)
      exe_pkg::OP_BEQ:  br_taken = (i_op1 == i_op2);
      exe_pkg::OP_BNE:  br_taken = (i_op1 != i_op2);
      exe_pkg::OP_BLT:  br_taken = ($signed(i_op1) < $signed(i_op2));
      exe_pkg::OP_BGE:  br_taken = ($signed(i_op1) >= $signed(i_op2));
      exe_pkg::OP_BLTU: br_taken = (i_op1 < i_op2);
      exe_pkg::OP_BGEU: br_taken = (i_op1 >= i_op2);
      default:          br_taken = 1'b0;
    endcase
  end

  // csr read-modify-write with the old value read back on rdata.
  assign is_csr   = i_ena && (i_inst_type == exe_pkg::TYPE_CSR);
  assign csr.ren  = is_csr;
  assign csr.addr = is_csr ? i_op2[11:0] : '0;

  always_comb begin
    case (i_op)
      exe_pkg::OP_CSRRW: csr_new = i_op1;
      exe_pkg::OP_CSRRS: csr_new = csr.rdata | i_op1;
      exe_pkg::OP_CSRRC: csr_new = csr.rdata & ~i_op1;
      default:           csr_new = '0;
    endcase
  end

  assign csr.wdata = is_csr ? csr_new : '0;
  assign csr.wen   = is_csr && csr.hit && i_commit; // only on the output handshake.

  always_comb begin
    o_pc_jmp      = 1'b0;
    o_pc_jmpaddr  = '0;
    o_rd_wdata    = '0;
    o_force_nowen = 1'b0;
    o_skip_cmt    = 1'b0;
    if (i_ena) begin
      case (i_inst_type)
        exe_pkg::TYPE_ALU: o_rd_wdata = alu_res;
        exe_pkg::TYPE_BRANCH: begin
          o_pc_jmp      = br_taken;
          o_pc_jmpaddr  = i_pc + i_op3;
          o_force_nowen = 1'b1;
        end
        exe_pkg::TYPE_JUMP: begin
          if (i_op == exe_pkg::OP_JAL) begin
            o_pc_jmp     = 1'b1;
            o_pc_jmpaddr = {jal_sum[63:1], 1'b0};
            o_rd_wdata   = i_pc + 64'd4; // link address.
          end
        end
        exe_pkg::TYPE_CSR: begin
          o_rd_wdata = csr.rdata;  // zero on a miss.
          o_skip_cmt = !csr.hit;
        end
        default: o_rd_wdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* exe_stage.sv */
// **********************************************************
// execute stage with req/ack handshakes, holding registers
// and output gating around the execute unit.
// **********************************************************

`timescale 1ns/10ps
`default_nettype none

module exe_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_dec_req,
  output logic                o_dec_ack,
  input  exe_pkg::inst_type_e i_inst_type,
  input  exe_pkg::op_e        i_op,
  input  exe_pkg::word_t      i_pc,
  input  exe_pkg::inst_t      i_inst,
  input  exe_pkg::word_t      i_op1,
  input  exe_pkg::word_t      i_op2,
  input  exe_pkg::word_t      i_op3,
  input  exe_pkg::ridx_t      i_rd,
  input  logic                i_rd_wen,
  input  logic                i_nocmt,
  input  logic                i_skipcmt,
  output logic                o_exe_req,
  input  logic                i_exe_ack,
  csr_if.unit                 csr,
  output exe_pkg::word_t      o_pc,
  output exe_pkg::inst_t      o_inst,
  output exe_pkg::ridx_t      o_rd,
  output logic                o_rd_wen,
  output logic                o_nocmt,
  output logic                o_skipcmt,
  output logic                o_pc_jmp,
  output exe_pkg::word_t      o_pc_jmpaddr,
  output exe_pkg::word_t      o_rd_wdata
);

  logic                busy;
  logic                dec_hs;
  logic                exe_hs;
  logic                force_nowen;
  logic                unit_skip;
  exe_pkg::inst_type_e type_q;
  exe_pkg::op_e        op_q;
  exe_pkg::word_t      pc_q;
  exe_pkg::inst_t      inst_q;
  exe_pkg::word_t      op1_q;
  exe_pkg::word_t      op2_q;
  exe_pkg::word_t      op3_q;
  exe_pkg::ridx_t      rd_q;
  logic                rd_wen_q;
  logic                nocmt_q;
  logic                skipcmt_q;

  assign exe_hs    = busy && i_exe_ack;
  assign o_dec_ack = !busy || exe_hs;  // free or emptying this cycle.
  assign dec_hs    = i_dec_req && o_dec_ack;
  assign o_exe_req = busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (dec_hs) begin
      busy <= 1'b1;
    end else if (exe_hs) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_hs) begin
      type_q    <= i_inst_type;
      op_q      <= i_op;
      pc_q      <= i_pc;
      inst_q    <= i_inst;
      op1_q     <= i_op1;
      op2_q     <= i_op2;
      op3_q     <= i_op3;
      rd_q      <= i_rd;
      rd_wen_q  <= i_rd_wen;
      nocmt_q   <= i_nocmt;
      skipcmt_q <= i_skipcmt;
    end
  end

  // outputs read zero while idle.
  assign o_pc      = busy ? pc_q : '0;
  assign o_inst    = busy ? inst_q : '0;
  assign o_rd      = busy ? rd_q : '0;
  assign o_rd_wen  = busy ? (rd_wen_q && !force_nowen) : 1'b0;
  assign o_nocmt   = busy ? nocmt_q : 1'b0;
  assign o_skipcmt = busy ? (skipcmt_q || unit_skip) : 1'b0;

  exe_unit exe_unit_inst (
    .i_ena         (busy),
    .i_inst_type   (type_q),
    .i_op          (op_q),
    .i_pc          (pc_q),
    .i_op1         (op1_q),
    .i_op2         (op2_q),
    .i_op3         (op3_q),
    .i_commit      (exe_hs),
    .csr           (csr),
    .o_pc_jmp      (o_pc_jmp),
    .o_pc_jmpaddr  (o_pc_jmpaddr),
    .o_rd_wdata    (o_rd_wdata),
    .o_force_nowen (force_nowen),
    .o_skip_cmt    (unit_skip)
  );

endmodule

`default_nettype wire

/* exe_top.sv */
// **********************************************************
// execute top level with the stage and the machine csr block.
// **********************************************************

`timescale 1ns/10ps
`default_nettype none

module exe_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_dec_req,
  output logic                o_dec_ack,
  input  exe_pkg::inst_type_e i_inst_type,
  input  exe_pkg::op_e        i_op,
  input  exe_pkg::word_t      i_pc,
  input  exe_pkg::inst_t      i_inst,
  input  exe_pkg::word_t      i_op1,
  input  exe_pkg::word_t      i_op2,
  input  exe_pkg::word_t      i_op3,
  input  exe_pkg::ridx_t      i_rd,
  input  logic                i_rd_wen,
  input  logic                i_nocmt,
  input  logic                i_skipcmt,
  output logic                o_exe_req,
  input  logic                i_exe_ack,
  output exe_pkg::word_t      o_pc,
  output exe_pkg::inst_t      o_inst,
  output exe_pkg::ridx_t      o_rd,
  output logic                o_rd_wen,
  output logic                o_nocmt,
  output logic                o_skipcmt,
  output logic                o_pc_jmp,
  output exe_pkg::word_t      o_pc_jmpaddr,
  output exe_pkg::word_t      o_rd_wdata
);

  csr_if csr_bus ();

  csr_regs csr_regs_inst (
    .clk (clk),
    .rst (rst),
    .csr (csr_bus.regs)
  );

  exe_stage exe_stage_inst (
    .clk          (clk),
    .rst          (rst),
    .i_dec_req    (i_dec_req),
    .o_dec_ack    (o_dec_ack),
    .i_inst_type  (i_inst_type),
    .i_op         (i_op),
    .i_pc         (i_pc),
    .i_inst       (i_inst),
    .i_op1        (i_op1),
    .i_op2        (i_op2),
    .i_op3        (i_op3),
    .i_rd         (i_rd),
    .i_rd_wen     (i_rd_wen),
    .i_nocmt      (i_nocmt),
    .i_skipcmt    (i_skipcmt),
    .o_exe_req    (o_exe_req),
    .i_exe_ack    (i_exe_ack),
    .csr          (csr_bus.unit),
    .o_pc         (o_pc),
    .o_inst       (o_inst),
    .o_rd         (o_rd),
    .o_rd_wen     (o_rd_wen),
    .o_nocmt      (o_nocmt),
    .o_skipcmt    (o_skipcmt),
    .o_pc_jmp     (o_pc_jmp),
    .o_pc_jmpaddr (o_pc_jmpaddr),
    .o_rd_wdata   (o_rd_wdata)
  );

endmodule

`default_nettype wire

/* exe_asserts.sv */
// ************************************************************
// handshake and csr write assertions bound into exe_stage.
// ************************************************************

`timescale 1ns/10ps
`default_nettype none

module exe_asserts (
  input logic           clk,
  input logic           rst,
  input logic           i_dec_req,
  input logic           o_dec_ack,
  input logic           o_exe_req,
  input logic           i_exe_ack,
  input exe_pkg::word_t o_pc,
  input exe_pkg::inst_t o_inst,
  input exe_pkg::word_t o_rd_wdata,
  input exe_pkg::word_t o_pc_jmpaddr,
  input logic           o_pc_jmp,
  input logic           o_rd_wen,
  input logic           csr_wen
);

  // a pending result holds until taken.
  a_hold: assert property (@(posedge clk) disable iff (rst)
    (o_exe_req && !i_exe_ack) |=> (o_exe_req &&
      $stable({o_pc, o_inst, o_rd_wdata, o_pc_jmpaddr, o_pc_jmp, o_rd_wen})))
    else $error("o_exe_req dropped or outputs changed before i_exe_ack");

  a_req_rise: assert property (@(posedge clk) disable iff (rst)
    (i_dec_req && o_dec_ack) |=> o_exe_req)
    else $error("o_exe_req not high one cycle after an input handshake");

  a_csr_write: assert property (@(posedge clk) disable iff (rst)
    csr_wen |-> (o_exe_req && i_exe_ack))
    else $error("csr write without an output handshake");

endmodule

bind exe_stage exe_asserts exe_asserts_inst (
  .clk          (clk),
  .rst          (rst),
  .i_dec_req    (i_dec_req),
  .o_dec_ack    (o_dec_ack),
  .o_exe_req    (o_exe_req),
  .i_exe_ack    (i_exe_ack),
  .o_pc         (o_pc),
  .o_inst       (o_inst),
  .o_rd_wdata   (o_rd_wdata),
  .o_pc_jmpaddr (o_pc_jmpaddr),
  .o_pc_jmp     (o_pc_jmp),
  .o_rd_wen     (o_rd_wen),
  .csr_wen      (csr.wen)
);

`default_nettype wire

/* tb_exe_top.sv */
// ************************************************************
// testbench for exe_top with clock, reset, lcg stimulus, a
// reference model with its own csr array and result checks.
// ************************************************************

`timescale 1ns/10ps
`default_nettype none

module tb_exe_top;

  localparam int NUM_INSTS      = 400;
  localparam int TIMEOUT_CYCLES = NUM_INSTS * 6 + 200;

  typedef struct packed {
    logic [4:0]     typ;
    logic [7:0]     op;
    exe_pkg::word_t pc;
    exe_pkg::inst_t inst;
    exe_pkg::word_t op1;
    exe_pkg::word_t op2;
    exe_pkg::word_t op3;
    exe_pkg::ridx_t rd;
    logic           rd_wen;
    logic           nocmt;
    logic           skipcmt;
  } txn_t;

  logic                clk;
  logic                rst;
  logic                i_dec_req;
  logic                o_dec_ack;
  exe_pkg::inst_type_e i_inst_type;
  exe_pkg::op_e        i_op;
  exe_pkg::word_t      i_pc;
  exe_pkg::inst_t      i_inst;
  exe_pkg::word_t      i_op1;
  exe_pkg::word_t      i_op2;
  exe_pkg::word_t      i_op3;
  exe_pkg::ridx_t      i_rd;
  logic                i_rd_wen;
  logic                i_nocmt;
  logic                i_skipcmt;
  logic                o_exe_req;
  logic                i_exe_ack;
  exe_pkg::word_t      o_pc;
  exe_pkg::inst_t      o_inst;
  exe_pkg::ridx_t      o_rd;
  logic                o_rd_wen;
  logic                o_nocmt;
  logic                o_skipcmt;
  logic                o_pc_jmp;
  exe_pkg::word_t      o_pc_jmpaddr;
  exe_pkg::word_t      o_rd_wdata;

  logic [31:0]    seed = 32'he4c6;
  exe_pkg::word_t csr_model [4];  // mtvec, mscratch, mepc, mcause.
  txn_t           pend [$];       // accepted and not yet taken.
  txn_t           cur;
  logic           dec_taken;
  logic [1:0]     stall_cnt;
  int             errors;
  int             committed;
  int             cycles;

  exe_top exe_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return {seed[15:0], seed[31:16]};  // low lcg bits repeat fast.
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (exp === got) else begin
      errors++;
      $display("[FAIL] t=%0t %s expected %h observed %h", $time, name, exp, got);
    end
  endtask

  task automatic check_idle();
    check_val("o_pc", 64'd0, o_pc);
    check_val("o_inst", 64'd0, 64'(o_inst));
    check_val("o_rd", 64'd0, 64'(o_rd));
    check_val("o_rd_wen", 64'd0, 64'(o_rd_wen));
    check_val("o_nocmt", 64'd0, 64'(o_nocmt));
    check_val("o_skipcmt", 64'd0, 64'(o_skipcmt));
    check_val("o_pc_jmp", 64'd0, 64'(o_pc_jmp));
    check_val("o_pc_jmpaddr", 64'd0, o_pc_jmpaddr);
    check_val("o_rd_wdata", 64'd0, o_rd_wdata);
  endtask

  function automatic exe_pkg::word_t alu_model(logic [7:0] op, exe_pkg::word_t a,
                                               exe_pkg::word_t b);
    case (op)
      exe_pkg::OP_ADD:  return a + b;
      exe_pkg::OP_SUB:  return a - b;
      exe_pkg::OP_AND:  return a & b;
      exe_pkg::OP_OR:   return a | b;
      exe_pkg::OP_XOR:  return a ^ b;
      exe_pkg::OP_SLL:  return a << b[5:0];
      exe_pkg::OP_SRL:  return a >> b[5:0];
      exe_pkg::OP_SRA:  return exe_pkg::word_t'($signed(a) >>> b[5:0]);
      exe_pkg::OP_SLT:  return {63'd0, $signed(a) < $signed(b)};
      exe_pkg::OP_SLTU: return {63'd0, a < b};
      default:          return 64'd0;
    endcase
  endfunction

  function automatic logic taken_model(logic [7:0] op, exe_pkg::word_t a, exe_pkg::word_t b);
    case (op)
      exe_pkg::OP_BEQ:  return a == b;
      exe_pkg::OP_BNE:  return a != b;
      exe_pkg::OP_BLT:  return $signed(a) < $signed(b);
      exe_pkg::OP_BGE:  return $signed(a) >= $signed(b);
      exe_pkg::OP_BLTU: return a < b;
      default:          return a >= b;
    endcase
  endfunction

  function automatic logic csr_slot(input exe_pkg::csr_addr_t a, output logic [1:0] idx);
    idx = 2'd0;
    case (a)
      exe_pkg::CSR_MTVEC:    idx = 2'd0;
      exe_pkg::CSR_MSCRATCH: idx = 2'd1;
      exe_pkg::CSR_MEPC:     idx = 2'd2;
      exe_pkg::CSR_MCAUSE:   idx = 2'd3;
      default:               return 1'b0;
    endcase
    return 1'b1;
  endfunction

  // expected result of one output handshake with the csr model updated once.
  task automatic check_commit(input txn_t t);
    exe_pkg::word_t exp_wdata;
    exe_pkg::word_t exp_jaddr;
    exe_pkg::word_t sum;
    exe_pkg::word_t nv;
    logic           exp_jmp;
    logic           exp_wen;
    logic           exp_skip;
    logic [1:0]     idx;
    exp_wdata = 64'd0;
    exp_jaddr = 64'd0;
    exp_jmp   = 1'b0;
    exp_wen   = t.rd_wen;
    exp_skip  = t.skipcmt;
    case (t.typ)
      exe_pkg::TYPE_ALU: exp_wdata = alu_model(t.op, t.op1, t.op2);
      exe_pkg::TYPE_BRANCH: begin
        exp_jmp   = taken_model(t.op, t.op1, t.op2);
        exp_jaddr = t.pc + t.op3;
        exp_wen   = 1'b0;
      end
      exe_pkg::TYPE_JUMP: begin
        sum       = t.op1 + t.op2;
        exp_jmp   = 1'b1;
        exp_jaddr = {sum[63:1], 1'b0};
        exp_wdata = t.pc + 64'd4;
      end
      default: begin
        if (csr_slot(t.op2[11:0], idx)) begin
          exp_wdata = csr_model[idx];
          case (t.op)
            exe_pkg::OP_CSRRW: nv = t.op1;
            exe_pkg::OP_CSRRS: nv = csr_model[idx] | t.op1;
            default:           nv = csr_model[idx] & ~t.op1;
          endcase
          if (idx == 2'd0) nv[1:0] = 2'b00;  // mtvec stays aligned.
          csr_model[idx] = nv;
        end else begin
          exp_skip = 1'b1;
        end
      end
    endcase
    check_val("o_pc", t.pc, o_pc);
    check_val("o_inst", 64'(t.inst), 64'(o_inst));
    check_val("o_rd", 64'(t.rd), 64'(o_rd));
    check_val("o_rd_wen", 64'(exp_wen), 64'(o_rd_wen));
    check_val("o_nocmt", 64'(t.nocmt), 64'(o_nocmt));
    check_val("o_skipcmt", 64'(exp_skip), 64'(o_skipcmt));
    check_val("o_pc_jmp", 64'(exp_jmp), 64'(o_pc_jmp));
    check_val("o_pc_jmpaddr", exp_jaddr, o_pc_jmpaddr);
    check_val("o_rd_wdata", exp_wdata, o_rd_wdata);
  endtask

  task automatic make_txn(output txn_t t);
    logic [31:0] pick;
    logic [31:0] r;
    pick      = next_rand();
    r         = next_rand();
    t.pc      = {next_rand(), next_rand() & 32'hffff_fffc};
    t.inst    = next_rand();
    t.op1     = {next_rand(), next_rand()};
    t.op2     = {next_rand(), next_rand()};
    t.op3     = {{52{r[11]}}, r[11:0]};  // branch offset.
    t.rd      = r[16:12];
    t.rd_wen  = r[17];
    t.nocmt   = (r[20:18] == 3'd0);
    t.skipcmt = (r[23:21] == 3'd0);
    case (pick[2:0])
      3'd0, 3'd1, 3'd2: begin
        t.typ = exe_pkg::TYPE_ALU;
        t.op  = 8'(pick[31:8] % 10);
      end
      3'd3, 3'd4: begin
        t.typ = exe_pkg::TYPE_BRANCH;
        t.op  = 8'(16 + pick[31:8] % 6);
        if (pick[4]) t.op2 = t.op1;  // equal operands now and then.
      end
      3'd5: begin
        t.typ = exe_pkg::TYPE_JUMP;
        t.op  = exe_pkg::OP_JAL;
      end
      default: begin
        t.typ = exe_pkg::TYPE_CSR;
        t.op  = 8'(48 + pick[31:8] % 3);
        case (pick[9:8])
          2'd0:    t.op2[11:0] = exe_pkg::CSR_MTVEC;
          2'd1:    t.op2[11:0] = exe_pkg::CSR_MSCRATCH;
          2'd2:    t.op2[11:0] = exe_pkg::CSR_MEPC;
          default: t.op2[11:0] = exe_pkg::CSR_MCAUSE;
        endcase
        if (pick[7:5] == 3'd0) t.op2[11:0] = {8'h7c, pick[13:10]};  // unimplemented.
      end
    endcase
  endtask

  task automatic drive_txn(input txn_t t);
    i_inst_type = exe_pkg::inst_type_e'(t.typ);
    i_op        = exe_pkg::op_e'(t.op);
    i_pc        = t.pc;
    i_inst      = t.inst;
    i_op1       = t.op1;
    i_op2       = t.op2;
    i_op3       = t.op3;
    i_rd        = t.rd;
    i_rd_wen    = t.rd_wen;
    i_nocmt     = t.nocmt;
    i_skipcmt   = t.skipcmt;
  endtask

  // outputs are sampled mid-cycle after the inputs have settled.
  always @(negedge clk) begin
    txn_t        t;
    logic [31:0] r;
    if (!rst) begin
      if (dec_taken) check_val("o_exe_req", 64'd1, 64'(o_exe_req));
      check_val("o_dec_ack", 64'(pend.size() == 0 || i_exe_ack), 64'(o_dec_ack));
      if (!o_exe_req) check_idle();
      if (o_exe_req && i_exe_ack) begin
        assert (pend.size() > 0) else begin
          errors++;
          $display("output handshake at %0t with no instruction outstanding", $time);
        end
        if (pend.size() > 0) begin
          t = pend.pop_front();
          check_commit(t);
        end
        committed++;
        r = next_rand();
        stall_cnt = r[1:0];  // ack low for 0 to 3 cycles.
      end
      dec_taken = i_dec_req && o_dec_ack;
      if (dec_taken) pend.push_back(cur);
    end
  end

  initial begin
    @(negedge rst);
    forever begin
      i_exe_ack = (stall_cnt == 2'd0);
      if (stall_cnt != 2'd0) stall_cnt = stall_cnt - 2'd1;
      @(posedge clk);
      #2;
    end
  end

  initial begin
    for (cycles = 0; cycles < TIMEOUT_CYCLES; cycles++) @(posedge clk);
    $display("timeout after %0d cycles, %0d of %0d results seen, %0d errors",
             cycles, committed, NUM_INSTS, errors);
    $display("Something failed");
    $finish;
  end

  initial begin
    int          n;
    int          gap;
    logic [31:0] r;
    rst       = 1'b1;
    i_dec_req = 1'b0;
    i_exe_ack = 1'b0;
    cur       = '0;
    drive_txn(cur);
    dec_taken = 1'b0;
    stall_cnt = 2'd0;
    errors    = 0;
    committed = 0;
    for (n = 0; n < 4; n++) csr_model[n] = 64'd0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    check_val("o_exe_req", 64'd0, 64'(o_exe_req));
    check_val("o_dec_ack", 64'd1, 64'(o_dec_ack));
    check_idle();
    for (n = 0; n < NUM_INSTS; n++) begin
      r   = next_rand();
      gap = (r[1:0] == 2'd0) ? int'(r[3:2]) : 0;
      repeat (gap) begin
        @(posedge clk);
        #2;
      end
      make_txn(cur);
      drive_txn(cur);
      i_dec_req = 1'b1;
      do @(posedge clk); while (!dec_taken);
      #2;
      i_dec_req = 1'b0;
    end
    wait (committed >= NUM_INSTS);
    repeat (3) @(posedge clk);
    assert (pend.size() == 0 && committed == NUM_INSTS) else begin
      errors++;
      $display("result count wrong: %0d seen, %0d still queued", committed, pend.size());
    end
    $display("done: %0d results checked, %0d errors", committed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
exe_pkg.sv
csr_if.sv
csr_regs.sv
exe_unit.sv
exe_stage.sv
exe_top.sv
exe_asserts.sv
tb_exe_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_exe_top -f tb.f -o sim_tb
out=$(./obj_dir/sim_tb || true)
echo "$out"
if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
